//--- list.f
source/microrocPkg.sv
source/slowControlLoader.sv
source/daqSequencer.sv
source/ramReadout.sv
source/creditSender.sv
source/microrocTop.sv
tb/asicModel.sv
tb/microrocTb.sv

//--- Makefile
# Verilator flow for the readout controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module microrocTop -f list.f

sim:
	verilator --binary --timing --assert --top-module microrocTb -f list.f -o simv
	./obj_dir/simv | tee sim.log
	@grep -q "Result: PASSED" sim.log
	@! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/microrocTb.sv
`timescale 1ns/100ps

module microrocTb import microrocPkg::*; ();

   logic        Clk = 1'b0;
   logic        rstN;
   scConfig_t   scConfig;
   logic        startLoad, acqStart, chipSatB, creditReturn;
   logic [15:0] acqTime;
   logic        endReadout, doutB, transmitOnB;           // From chip model
   logic        srRstB, srCk, srIn, configDone;
   logic        pwrOn, startAcq, startReadout, acqDone;
   outWord_t    outWord;
   logic        outValid, overflow;

   logic [31:0]         stimSeed = 32'h40b5;              // Stimulus LCG state
   logic [31:0]         credSeed = 32'h40b5;              // Credit delay LCG state
   outWord_t            expQ [$];                         // Words still expected
   logic [ScLength-1:0] scBits;                           // Bits seen on srCk rises
   logic                srCkLast = 1'b0;
   int                  scBitCnt, rxCount, owed, errorCount, testsRun, testsFailed;
   int                  srRstLowCnt;                      // Cycles with srRstB low
   bit                  holdCredits;                      // Withhold credit return

   always #10 Clk = ~Clk;                                 // 20 ns period

   microrocTop microrocTop_inst (.*);

   asicModel asicModel_inst (
      .Clk(Clk), .startReadout(startReadout), .doutB(doutB),
      .transmitOnB(transmitOnB), .endReadout(endReadout)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Random numbers and reporting
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] lcgStep(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [15:0] rand16();
      stimSeed = lcgStep(stimSeed);
      return stimSeed[31:16];                             // Upper bits are the better ones
   endfunction

   function automatic int randBelow(input int n);
      stimSeed = lcgStep(stimSeed);
      return int'({16'd0, stimSeed[31:16]} % 32'(n));
   endfunction

   task automatic reportMismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      errorCount++;
   endtask

   task automatic reportTimeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      errorCount++;
   endtask

   task automatic endTest(input string name, input int errsBefore);
      testsRun++;
      if (errorCount == errsBefore) begin
         $display("Test %s: ok", name);
      end else begin
         testsFailed++;
         $display("Test %s: failed with %0d errors", name, errorCount - errsBefore);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitors, slow-control bits, output words and credit return
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge Clk) begin
      if (srCk && !srCkLast) begin
         scBits = {scBits[ScLength-2:0], srIn};           // MSB arrives first
         scBitCnt++;
      end
      if (rstN && !srRstB) begin
         srRstLowCnt++;                                   // Chip register reset window
      end
      srCkLast = srCk;
   end

   always @(posedge Clk) begin
      if (rstN && outValid) begin
         rxCount++;
         owed++;                                          // One credit per word
         assert (expQ.size() != 0) else begin
            $display("Unexpected output word %h at %0t ns", outWord, $time);
            errorCount++;
         end
         if (expQ.size() != 0) begin
            assert (outWord == expQ[0]) else reportMismatch($sformatf(
               "word %0d is %h, expected %h", rxCount, outWord, expQ[0]));
            void'(expQ.pop_front());
         end
      end
   end

   initial begin
      int delay;
      creditReturn <= 1'b0;
      forever begin
         @(posedge Clk);
         if (owed > 0 && !holdCredits) begin
            credSeed = lcgStep(credSeed);
            delay    = int'({16'd0, credSeed[31:16]} % 32'd6);
            repeat (delay) @(posedge Clk);
            creditReturn <= 1'b1;
            owed--;
            @(posedge Clk);
            creditReturn <= 1'b0;                         // One cycle pulse
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic queueFrame(input int hits);
      outWord_t    e;
      logic [15:0] r;
      r                     = rand16();
      e.data.header.chipHeader = r[7:0];
      e.data.header.reserved   = r[12:8];
      e.data.header.hitCount   = 3'(hits);
      e.isHeader            = 1'b1;
      e.last                = (hits == 0);                // Lone header ends frame
      expQ.push_back(e);
      asicModel_inst.loadWord(e.data.raw);
      for (int i = 0; i < hits; i++) begin
         e.data.raw = rand16();
         e.isHeader = 1'b0;
         e.last     = (i == hits - 1);
         expQ.push_back(e);
         asicModel_inst.loadWord(e.data.raw);
      end
   endtask

   // One acquisition cycle with timing checks, satAt of 0 means no saturation
   task automatic runAcquisition(input int winLen, input int satAt);
      int cycles;
      int highCnt;
      int expHigh;
      bit asicTimeout;
      expHigh = (satAt > 0) ? satAt + 1 : winLen;
      highCnt = 0;
      cycles  = 0;
      fork
         asicModel_inst.streamFrames(asicTimeout);
         begin
            acqStart <= 1'b1;
            acqTime  <= 16'(winLen);
            @(posedge Clk);
            acqStart <= 1'b0;
            @(posedge Clk);
            assert (pwrOn && !startAcq) else reportMismatch("pwrOn not first after acqStart");
            @(posedge Clk);
            while (startAcq && cycles < 100) begin
               highCnt++;
               if (highCnt == satAt) begin
                  chipSatB <= 1'b0;                       // Chip memory full
               end
               @(posedge Clk);
               cycles++;
            end
            chipSatB <= 1'b1;
            assert (highCnt == expHigh) else reportMismatch($sformatf(
               "startAcq high for %0d cycles, expected %0d", highCnt, expHigh));
            assert (startReadout) else reportMismatch("no startReadout after startAcq fell");
            @(posedge Clk);
            assert (!startReadout) else reportMismatch("startReadout longer than 1 cycle");
            cycles = 0;
            while (!endReadout && cycles < 400) begin
               @(posedge Clk);
               cycles++;
            end
            if (!endReadout) begin
               reportTimeout("endReadout from the chip model");
            end else begin
               assert (pwrOn) else reportMismatch("pwrOn fell before endReadout");
               @(posedge Clk);
               assert (!pwrOn && acqDone) else reportMismatch("pwrOn and acqDone after end");
            end
         end
      join
      if (asicTimeout) begin
         reportTimeout("startReadout at the chip model");
      end
   endtask

   task automatic waitDrained();
      int cycles;
      cycles = 0;
      while ((expQ.size() != 0 || owed != 0 || creditReturn) && cycles < 600) begin
         @(posedge Clk);
         cycles++;
      end
      if (expQ.size() != 0 || owed != 0) begin
         reportTimeout("all expected words and credits");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [47:0] raw;
      scConfig_t   cfg;
      int          errs, cycles, rxStart;
      rstN      <= 1'b0;
      scConfig  <= '0;
      startLoad <= 1'b0;
      acqStart  <= 1'b0;
      acqTime   <= '0;
      chipSatB  <= 1'b1;
      repeat (10) @(posedge Clk);
      rstN <= 1'b1;
      @(posedge Clk);

      errs          = errorCount;                         // Slow control
      raw[47:32]    = rand16();
      raw[31:16]    = rand16();
      raw[15:0]     = rand16();
      cfg           = raw[ScLength-1:0];
      scBitCnt      = 0;
      srRstLowCnt   = 0;
      scConfig  <= cfg;
      startLoad <= 1'b1;
      @(posedge Clk);
      startLoad <= 1'b0;
      cycles = 0;
      while (!configDone && cycles < 300) begin
         @(posedge Clk);
         cycles++;
      end
      if (!configDone) begin
         reportTimeout("configDone");
      end
      assert (scBitCnt == ScLength) else reportMismatch($sformatf(
         "%0d srCk rises, expected %0d", scBitCnt, ScLength));
      assert (scBits == cfg) else reportMismatch($sformatf(
         "shifted %h, expected %h", scBits, cfg));
      assert (srRstLowCnt == 2) else reportMismatch($sformatf(
         "srRstB low for %0d cycles, expected 2", srRstLowCnt));
      assert (srRstB) else reportMismatch("srRstB not released after the load");
      endTest("slow control", errs);

      errs = errorCount;                                  // Acquisition timing
      queueFrame(randBelow(MaxHits + 1));
      runAcquisition(1 + randBelow(40), 0);
      waitDrained();
      endTest("acquisition timing", errs);

      errs = errorCount;                                  // Early stop on saturation
      queueFrame(randBelow(MaxHits + 1));
      runAcquisition(40, 1 + randBelow(20));
      waitDrained();
      endTest("early stop", errs);

      errs = errorCount;                                  // Frame decoding
      for (int f = 0; f < 20; f++) begin
         queueFrame(randBelow(MaxHits + 1));
         runAcquisition(1 + randBelow(8), 0);
      end
      waitDrained();
      assert (!overflow) else reportMismatch("overflow set without back-pressure");
      endTest("frame decoding", errs);

      errs        = errorCount;                           // Credit back-pressure
      rxStart     = rxCount;
      holdCredits = 1'b1;
      queueFrame(6);
      queueFrame(6);                                      // 14 words back to back
      runAcquisition(4, 0);
      repeat (20) @(posedge Clk);
      assert (rxCount - rxStart == OutCredits) else reportMismatch($sformatf(
         "%0d words without credit return, expected %0d", rxCount - rxStart, OutCredits));
      assert (overflow) else reportMismatch("overflow not set after drops");
      holdCredits = 1'b0;
      cycles      = 0;
      while (rxCount - rxStart < OutCredits + BufDepth && cycles < 400) begin
         @(posedge Clk);
         cycles++;
      end
      if (rxCount - rxStart < OutCredits + BufDepth) begin
         reportTimeout("the buffered words after credit release");
      end
      repeat (40) @(posedge Clk);
      assert (rxCount - rxStart == OutCredits + BufDepth) else reportMismatch($sformatf(
         "%0d words in total, expected %0d", rxCount - rxStart, OutCredits + BufDepth));
      assert (expQ.size() == 2) else reportMismatch($sformatf(
         "%0d words left over, expected 2 dropped", expQ.size()));
      $display("Dropped words: %0d", expQ.size());
      expQ.delete();
      endTest("credit back-pressure", errs);

      $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
      if (errorCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- tb/asicModel.sv
`timescale 1ns/100ps

module asicModel (
   input  logic Clk,
   input  logic startReadout,                             // Readout request from DUT
   output logic doutB,                                    // Serial data, active low
   output logic transmitOnB,                              // Data valid, active low
   output logic endReadout                                // Readout finished pulse
);

   logic [15:0] txWords [$];                              // Words of the next readout

   initial begin
      doutB       <= 1'b1;
      transmitOnB <= 1'b1;
      endReadout  <= 1'b0;
   end

   task automatic loadWord(input logic [15:0] w);
      txWords.push_back(w);
   endtask

   // Waits for the request, streams every loaded word MSB first, then ends the readout
   task automatic streamFrames(output bit timedOut);
      int          waitCnt;
      logic [15:0] w;
      waitCnt  = 0;
      timedOut = 1'b0;
      @(posedge Clk);
      while (!startReadout && waitCnt < 200) begin
         @(posedge Clk);
         waitCnt++;
      end
      if (!startReadout) begin
         timedOut = 1'b1;                                 // No request seen
      end else begin
         while (txWords.size() != 0) begin
            w = txWords.pop_front();
            for (int i = 15; i >= 0; i--) begin
               transmitOnB <= 1'b0;
               doutB       <= ~w[i];                      // Pin is inverted
               @(posedge Clk);
            end
         end
         transmitOnB <= 1'b1;
         doutB       <= 1'b1;
         repeat (2) @(posedge Clk);                       // Gap before end pulse
         endReadout <= 1'b1;
         @(posedge Clk);
         endReadout <= 1'b0;
      end
   endtask

endmodule

//--- source/microrocTop.sv
`timescale 1ns/100ps

module microrocTop import microrocPkg::*; (
   input  logic        Clk,
   input  logic        rstN,
   input  scConfig_t   scConfig,                          // Slow-control word
   input  logic        startLoad,
   input  logic        acqStart,
   input  logic [15:0] acqTime,
   input  logic        chipSatB,                          // Chip pin
   input  logic        endReadout,                        // Chip pin
   input  logic        doutB,                             // Chip pin
   input  logic        transmitOnB,                       // Chip pin
   input  logic        creditReturn,                      // From downstream
   output logic        srRstB,                            // Chip pin
   output logic        srCk,                              // Chip pin
   output logic        srIn,                              // Chip pin
   output logic        configDone,
   output logic        pwrOn,                             // Chip pin
   output logic        startAcq,                          // Chip pin
   output logic        startReadout,                      // Chip pin
   output logic        acqDone,
   output outWord_t    outWord,                           // To downstream
   output logic        outValid,
   output logic        overflow
);

   outWord_t rdWord;                                      // Deserialized word
   logic     rdWordValid;

   ////////////////////////////////////////////////////////////////////////////
   // Input side
   ////////////////////////////////////////////////////////////////////////////
   slowControlLoader slowControlLoader_inst (
      .Clk(Clk), .rstN(rstN), .scConfig(scConfig), .startLoad(startLoad),
      .srRstB(srRstB), .srCk(srCk), .srIn(srIn), .configDone(configDone)
   );

   daqSequencer daqSequencer_inst (
      .Clk(Clk), .rstN(rstN), .acqStart(acqStart), .acqTime(acqTime),
      .chipSatB(chipSatB), .endReadout(endReadout), .pwrOn(pwrOn),
      .startAcq(startAcq), .startReadout(startReadout), .acqDone(acqDone)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Readout and output side
   ////////////////////////////////////////////////////////////////////////////
   ramReadout ramReadout_inst (
      .Clk(Clk), .rstN(rstN), .doutB(doutB), .transmitOnB(transmitOnB),
      .word(rdWord), .wordValid(rdWordValid)
   );

   creditSender creditSender_inst (
      .Clk(Clk), .rstN(rstN), .word(rdWord), .wordValid(rdWordValid),
      .creditReturn(creditReturn), .startLoad(startLoad), .acqStart(acqStart),
      .outWord(outWord), .outValid(outValid), .overflow(overflow)
   );

endmodule

//--- source/creditSender.sv
`timescale 1ns/100ps

module creditSender import microrocPkg::*; (
   input  logic     Clk,
   input  logic     rstN,
   input  outWord_t word,                                 // Word from readout
   input  logic     wordValid,
   input  logic     creditReturn,                         // One credit back
   input  logic     startLoad,                            // Clears overflow
   input  logic     acqStart,                             // Clears overflow
   output outWord_t outWord,
   output logic     outValid,
   output logic     overflow                              // Sticky drop flag
);

   outWord_t           fifoMem [BufDepth];                // Circular buffer
   logic [PtrW-1:0]    wrPtr;
   logic [PtrW-1:0]    rdPtr;
   logic [PtrW:0]      count;                             // Entries held
   logic [CreditW-1:0] credits;                           // Credits on hand
   logic [CreditW-1:0] creditNext;                        // After this cycle
   logic               canSend;
   logic               pop;                               // Send from buffer
   logic               bypass;                            // Send input directly
   logic               push;                              // Store input
   logic               drop;                              // Input lost

   ////////////////////////////////////////////////////////////////////////////
   // Send decision
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      creditNext = credits + CreditW'(creditReturn) - CreditW'(outValid);  // Send spends 1
      canSend    = (creditNext != '0);
      pop        = canSend && (count != '0);              // Oldest word first
      bypass     = canSend && (count == '0) && wordValid;
      push       = wordValid && !bypass && ((count != (PtrW + 1)'(BufDepth)) || pop);
      drop       = wordValid && !bypass && !push;         // Buffer full
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         wrPtr    <= '0;
         rdPtr    <= '0;
         count    <= '0;
         credits  <= CreditW'(OutCredits);
         outValid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         credits  <= creditNext;
         outValid <= pop || bypass;
         count    <= count + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
         if (push) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         if (startLoad || acqStart) begin
            overflow <= 1'b0;                             // New run
         end
         if (drop) begin
            overflow <= 1'b1;
         end
      end
   end

   // Buffer storage and output payload
   always_ff @(posedge Clk) begin
      if (push) begin
         fifoMem[wrPtr] <= word;
      end
      if (pop) begin
         outWord <= fifoMem[rdPtr];
      end else if (bypass) begin
         outWord <= word;
      end
   end

   // Downstream never sees a word without a credit behind it
   assert property (@(posedge Clk) disable iff (!rstN) outValid |-> credits != '0);
   // Downstream never returns more than it was given
   assert property (@(posedge Clk) disable iff (!rstN) credits <= CreditW'(OutCredits));

endmodule

//--- source/ramReadout.sv
`timescale 1ns/100ps

module ramReadout import microrocPkg::*; (
   input  logic     Clk,
   input  logic     rstN,
   input  logic     doutB,                                // Serial data, active low
   input  logic     transmitOnB,                          // Data valid, active low
   output outWord_t word,                                 // Decoded word
   output logic     wordValid                             // One-cycle word strobe
);

   logic [WordBits-2:0] shiftReg;                         // First 15 bits of a word
   logic [BitCntW-1:0]  bitCnt;                           // Bit position in word
   logic                expectHeader;                     // Next word opens a frame
   logic [HitCntW-1:0]  hitsLeft;                         // Hits still due in frame
   logic                wordDone;                         // 16th bit on the pin
   readoutWord_u        nextWord;                         // Word including current bit

   always_comb begin
      nextWord.raw = {shiftReg, ~doutB};                  // Invert pin polarity
   end

   assign wordDone = !transmitOnB && (bitCnt == BitCntW'(WordBits - 1));

   ////////////////////////////////////////////////////////////////////////////
   // Bit counting and frame parsing
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         bitCnt       <= '0;
         expectHeader <= 1'b1;
         hitsLeft     <= '0;
         wordValid    <= 1'b0;
      end else if (transmitOnB) begin
         bitCnt    <= '0;
         wordValid <= 1'b0;
         if (bitCnt != '0) begin
            expectHeader <= 1'b1;                         // Partial word dropped
         end
      end else begin
         bitCnt    <= bitCnt + 1'b1;                      // Wraps every 16 bits
         wordValid <= wordDone;
         if (wordDone) begin
            if (expectHeader) begin
               hitsLeft     <= nextWord.header.hitCount;
               expectHeader <= (nextWord.header.hitCount == '0);   // Empty frame
            end else begin
               hitsLeft     <= hitsLeft - 1'b1;
               expectHeader <= (hitsLeft == HitCntW'(1));
            end
         end
      end
   end

   // Shift register and output word
   always_ff @(posedge Clk) begin
      if (!transmitOnB) begin
         shiftReg <= nextWord.raw[WordBits-2:0];          // Keep newest 15 bits
      end
      if (wordDone) begin
         word.data     <= nextWord;
         word.isHeader <= expectHeader;
         word.last     <= expectHeader ? (nextWord.header.hitCount == '0)
                                       : (hitsLeft == HitCntW'(1));
      end
   end

   // A frame in progress always has hits still due
   assert property (@(posedge Clk) disable iff (!rstN) !expectHeader |-> hitsLeft != '0);

endmodule

//--- source/daqSequencer.sv
`timescale 1ns/100ps

module daqSequencer (
   input  logic        Clk,
   input  logic        rstN,
   input  logic        acqStart,                          // One-cycle start pulse
   input  logic [15:0] acqTime,                           // Window length in cycles
   input  logic        chipSatB,                          // Chip memory full, active low
   input  logic        endReadout,                        // Chip finished readout
   output logic        pwrOn,                             // Power pulsing
   output logic        startAcq,                          // Acquisition window
   output logic        startReadout,                      // Readout request pulse
   output logic        acqDone                            // Cycle finished pulse
);

   typedef enum logic [2:0] {
      Idle,                                               // Waiting for acqStart
      PowerUp,                                            // Power settling cycle
      Acquire,                                            // Window open
      ReadReq,                                            // Readout request issued
      WaitEnd                                             // Waiting for chip
   } daqState_t;

   daqState_t   state;
   logic [15:0] winCnt;                                   // Window cycles left

   ////////////////////////////////////////////////////////////////////////////
   // Sequencer FSM, all outputs registered
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         state        <= Idle;
         winCnt       <= '0;
         pwrOn        <= 1'b0;
         startAcq     <= 1'b0;
         startReadout <= 1'b0;
         acqDone      <= 1'b0;
      end else begin
         acqDone <= 1'b0;                                 // Pulse by default
         case (state)
            Idle: begin
               if (acqStart) begin
                  pwrOn <= 1'b1;                          // 1 cycle after start
                  state <= PowerUp;
               end
            end
            PowerUp: begin
               startAcq <= 1'b1;                          // 2 cycles after start
               winCnt   <= acqTime;
               state    <= Acquire;
            end
            Acquire: begin
               if (winCnt <= 16'd1 || !chipSatB) begin
                  startAcq     <= 1'b0;                   // Window over or chip full
                  startReadout <= 1'b1;
                  state        <= ReadReq;
               end else begin
                  winCnt <= winCnt - 16'd1;
               end
            end
            ReadReq: begin
               startReadout <= 1'b0;                      // Single cycle request
               state        <= WaitEnd;
            end
            WaitEnd: begin
               if (endReadout) begin
                  pwrOn   <= 1'b0;
                  acqDone <= 1'b1;                        // Same cycle as power off
                  state   <= Idle;
               end
            end
            default: state <= Idle;
         endcase
      end
   end

   // Readout request only after the window has closed
   assert property (@(posedge Clk) disable iff (!rstN) !(startReadout && startAcq));

endmodule

//--- source/slowControlLoader.sv
`timescale 1ns/100ps

module slowControlLoader import microrocPkg::*; (
   input  logic      Clk,
   input  logic      rstN,
   input  scConfig_t scConfig,                            // Word to load
   input  logic      startLoad,                           // One-cycle start pulse
   output logic      srRstB,                              // Register reset, active low
   output logic      srCk,                                // Register clock
   output logic      srIn,                                // Register serial data
   output logic      configDone                           // Load complete
);

   logic [ScLength-1:0] shiftReg;                         // Bits still to send
   logic [ScCntW-1:0]   bitCnt;                           // Bits already sent
   logic                busy;                             // Load in progress
   logic                rstPhase;                         // srRstB low window
   logic                rstCnt;                           // Cycle within reset window
   logic                phase;                            // 0 clock low, 1 clock high

   assign srIn = shiftReg[ScLength-1];                    // MSB drives the pin

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         shiftReg   <= '0;
         bitCnt     <= '0;
         busy       <= 1'b0;
         rstPhase   <= 1'b0;
         rstCnt     <= 1'b0;
         phase      <= 1'b0;
         srRstB     <= 1'b1;
         srCk       <= 1'b0;
         configDone <= 1'b0;
      end else if (startLoad && !busy) begin
         shiftReg   <= scConfig;                          // Capture config
         bitCnt     <= '0;
         busy       <= 1'b1;
         rstPhase   <= 1'b1;
         rstCnt     <= 1'b0;
         phase      <= 1'b0;
         srRstB     <= 1'b0;                              // Reset chip register
         srCk       <= 1'b0;
         configDone <= 1'b0;
      end else if (busy) begin
         if (rstPhase) begin
            if (rstCnt) begin
               rstPhase <= 1'b0;
               srRstB   <= 1'b1;                          // Release after 2 cycles
            end else begin
               rstCnt <= 1'b1;
            end
         end else if (!phase) begin
            srCk  <= 1'b1;                                // Data stable, clock high
            phase <= 1'b1;
         end else begin
            srCk     <= 1'b0;
            phase    <= 1'b0;
            shiftReg <= {shiftReg[ScLength-2:0], 1'b0};   // Next bit while clock low
            if (bitCnt == ScCntW'(ScLength - 1)) begin
               busy       <= 1'b0;
               configDone <= 1'b1;                        // After last high phase
            end else begin
               bitCnt <= bitCnt + 1'b1;
            end
         end
      end
   end

   // Clock edges only come from a running load past its reset window
   assert property (@(posedge Clk) disable iff (!rstN) $rose(srCk) |-> busy && srRstB);

endmodule

//--- source/microrocPkg.sv
package microrocPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////////////////////
   localparam int ScLength   = 46;                        // Slow-control bits per load
   localparam int ScCntW     = $clog2(ScLength);          // Bit counter width
   localparam int MaxHits    = 7;                         // Largest header hit count
   localparam int HitCntW    = $clog2(MaxHits + 1);       // Remaining-hits counter width
   localparam int WordBits   = 16;                        // Readout word length
   localparam int BitCntW    = $clog2(WordBits);          // Serial bit counter width
   localparam int BufDepth   = 8;                         // Output buffer entries
   localparam int PtrW       = $clog2(BufDepth);          // Buffer pointer width
   localparam int OutCredits = 4;                         // Credits held after reset
   localparam int CreditW    = $clog2(OutCredits + 1);    // Credit counter width

   ////////////////////////////////////////////////////////////////////////////
   // Slow-control word, first field leaves first
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [7:0] chipHeader;                             // Chip ID
      logic [9:0] dac2Vth;                                // Threshold DAC 2
      logic [9:0] dac1Vth;                                // Threshold DAC 1
      logic [9:0] dac0Vth;                                // Threshold DAC 0
      logic [7:0] enables;                                // Block enables
   } scConfig_t;

   ////////////////////////////////////////////////////////////////////////////
   // Readout word views
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [7:0] chipHeader;                             // Chip ID echoed in frame
      logic [4:0] reserved;                               // Unused bits
      logic [2:0] hitCount;                               // Hits following this header
   } readoutHeader_t;

   typedef struct packed {
      logic [5:0] channel;                                // Hit channel
      logic [1:0] discri;                                 // Discriminator pattern
      logic [7:0] bcidLow;                                // Low BCID byte
   } readoutHit_t;

   typedef union packed {
      readoutHeader_t        header;                      // First word of a frame
      readoutHit_t           hit;                         // Following words
      logic [WordBits-1:0]   raw;                         // Shift register view
   } readoutWord_u;

   // Word as carried to the output port
   typedef struct packed {
      readoutWord_u data;                                 // Payload
      logic         isHeader;                             // Set on frame header
      logic         last;                                 // Set on final frame word
   } outWord_t;

endpackage
